/* common/corr_pkg.sv */
`default_nettype none

package corr_pkg;

  ////////////////////////////////
  // sizes
  ////////////////////////////////

  // interleaved lanes per beat
  localparam int num_lanes = 4;

  // signed input sample
  localparam int sample_width = 6;

  // signed partial and final sums
  // 8 taps of magnitude 32 at most, so 12 bits never wraps
  localparam int acc_width = 12;

  // taps in the correlator
  localparam int corr_length = 8;

  // lane index width
  localparam int lane_width = 2;

  ////////////////////////////////
  // coefficients
  ////////////////////////////////

  // 1 adds, 0 subtracts
  // msb for the newest sample, lsb for the oldest
  localparam logic [corr_length-1:0] corr_code = 8'b1011_0010;

  ////////////////////////////////
  // types
  ////////////////////////////////

  typedef logic signed [sample_width-1:0] sample_t;
  typedef logic signed [acc_width-1:0]    acc_t;
  typedef logic [lane_width-1:0]          lane_t;

  typedef enum logic {
    seq_idle,
    seq_issue
  } seq_state_t;

  // derived bus widths and marks
  localparam int    s_data_width = num_lanes * sample_width;
  localparam int    m_data_width = num_lanes * acc_width;
  localparam lane_t last_lane    = lane_t'(num_lanes - 1);

endpackage

`default_nettype wire

/* corr_engine/tap_delay_ram.sv */
`timescale 1ns/1ns
`default_nettype none

module tap_delay_ram (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    wr_en,
  input  wire  corr_pkg::lane_t  wr_lane,
  input  wire  corr_pkg::acc_t   wr_data,
  input  wire  corr_pkg::lane_t  rd_lane,
  output corr_pkg::acc_t         rd_data
);

  // one partial sum per lane
  corr_pkg::acc_t mem [corr_pkg::num_lanes];

  // cleared sums act as an all-zero sample history
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < corr_pkg::num_lanes; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[wr_lane] <= wr_data;
    end
  end

  // combinational read, old value until the edge
  assign rd_data = mem[rd_lane];

endmodule

`default_nettype wire

/* corr_engine/corr_engine.sv */
`timescale 1ns/1ns
`default_nettype none

module corr_engine (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       lane_valid,
  input  wire  corr_pkg::lane_t     lane_idx,
  input  wire  corr_pkg::sample_t   lane_sample,
  input  wire                       lane_last,
  output logic                      acc_valid,
  output corr_pkg::lane_t           acc_lane,
  output corr_pkg::acc_t            acc_value,
  output logic                      acc_last
);

  localparam int last_tap = corr_pkg::corr_length - 1;

  // sample widened to the sum width
  corr_pkg::acc_t ext_sample;

  // per tap, the sum coming in and the sum going out
  corr_pkg::acc_t prev_sum [corr_pkg::corr_length];
  corr_pkg::acc_t tap_sum  [corr_pkg::corr_length];

  // stored sums read back for the current lane
  corr_pkg::acc_t store_rd [corr_pkg::corr_length-1];

  ////////////////////////////////
  // sample sign extension
  ////////////////////////////////

  assign ext_sample = {
    {(corr_pkg::acc_width - corr_pkg::sample_width){lane_sample[corr_pkg::sample_width-1]}},
    lane_sample
  };

  ////////////////////////////////
  // tap chain
  ////////////////////////////////

  // tap k picks up what tap k-1 left for this lane one beat earlier
  // tap 0 starts a fresh sum, its term ends up the oldest in the output
  for (genvar k = 0; k < corr_pkg::corr_length; k++) begin : g_tap

    if (k == 0) begin : g_head
      assign prev_sum[k] = '0;
    end else begin : g_link
      assign prev_sum[k] = store_rd[k-1];
    end

    // coefficient is +1 or -1, so just add or subtract
    assign tap_sum[k] = corr_pkg::corr_code[k] ? prev_sum[k] + ext_sample
                                               : prev_sum[k] - ext_sample;

    // every tap but the last parks its sum until the same lane returns
    if (k < last_tap) begin : g_store
      tap_delay_ram u_tap_delay_ram (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (lane_valid),
        .wr_lane (lane_idx),
        .wr_data (tap_sum[k]),
        .rd_lane (lane_idx),
        .rd_data (store_rd[k])
      );
    end

  end

  ////////////////////////////////
  // output register
  ////////////////////////////////

  // one clock from lane_valid to acc_valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= lane_valid;
    end
  end

  // final tap sum with its lane marks
  always_ff @(posedge clk) begin
    if (lane_valid) begin
      acc_lane  <= lane_idx;
      acc_value <= tap_sum[last_tap];
      acc_last  <= lane_last;
    end
  end

endmodule

`default_nettype wire

/* design/lane_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module lane_sequencer (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                s_valid,
  input  wire  [corr_pkg::s_data_width-1:0]  s_data,
  // collector can take another batch
  input  wire                                room,
  output logic                               s_ready,
  output logic                               lane_valid,
  output corr_pkg::lane_t                    lane_idx,
  output corr_pkg::sample_t                  lane_sample,
  output logic                               lane_last
);

  corr_pkg::seq_state_t              state;
  corr_pkg::lane_t                   lane_cnt;
  logic [corr_pkg::s_data_width-1:0] beat_q;
  logic                              s_fire;

  ////////////////////////////////
  // input handshake
  ////////////////////////////////

  // only take a beat when idle and the collector has space
  assign s_ready = (state == corr_pkg::seq_idle) & room;
  assign s_fire  = s_valid & s_ready;

  // whole beat held while its lanes go out
  always_ff @(posedge clk) begin
    if (s_fire) begin
      beat_q <= s_data;
    end
  end

  ////////////////////////////////
  // state machine
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= corr_pkg::seq_idle;
      lane_cnt <= '0;
    end else begin
      case (state)
        corr_pkg::seq_idle: begin
          if (s_fire) begin
            state    <= corr_pkg::seq_issue;
            // first lane goes out next clock
            lane_cnt <= '0;
          end
        end
        corr_pkg::seq_issue: begin
          if (lane_cnt == corr_pkg::last_lane) begin
            // beat done, back for the next one
            state <= corr_pkg::seq_idle;
          end else begin
            lane_cnt <= lane_cnt + corr_pkg::lane_t'(1);
          end
        end
        default: begin
          state <= corr_pkg::seq_idle;
        end
      endcase
    end
  end

  ////////////////////////////////
  // lane outputs
  ////////////////////////////////

  // one lane per clock while issuing
  assign lane_valid = (state == corr_pkg::seq_issue);
  assign lane_idx   = lane_cnt;

  // lane 0 sits in the low bits
  assign lane_sample = corr_pkg::sample_t'(
    beat_q[lane_cnt*corr_pkg::sample_width +: corr_pkg::sample_width]);

  // tells the collector the batch is complete
  assign lane_last = lane_valid & (lane_cnt == corr_pkg::last_lane);

endmodule

`default_nettype wire

/* design/result_collector.sv */
`timescale 1ns/1ns
`default_nettype none

module result_collector (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                acc_valid,
  input  wire  corr_pkg::lane_t              acc_lane,
  input  wire  corr_pkg::acc_t               acc_value,
  input  wire                                acc_last,
  input  wire                                m_ready,
  output logic                               m_valid,
  output logic [corr_pkg::m_data_width-1:0]  m_data,
  // a new beat may start
  output logic                               room
);

  // assembly buffer and its value with the current lane merged in
  logic [corr_pkg::m_data_width-1:0] asm_buf;
  logic [corr_pkg::m_data_width-1:0] asm_next;
  logic                              asm_busy;
  logic                              assembling;

  // staging slot behind the output register
  logic [corr_pkg::m_data_width-1:0] stg_data;
  logic                              stg_valid;

  logic batch_done;
  logic out_free;
  logic out_load;
  logic stg_load;
  logic stg_clear;

  ////////////////////////////////
  // assembly
  ////////////////////////////////

  always_comb begin
    asm_next = asm_buf;
    asm_next[acc_lane*corr_pkg::acc_width +: corr_pkg::acc_width] = acc_value;
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      asm_buf <= asm_next;
    end
  end

  // busy from the first lane until the last one arrives
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      asm_busy <= 1'b0;
    end else if (acc_valid) begin
      asm_busy <= ~acc_last;
    end
  end

  assign assembling = asm_busy | acc_valid;
  assign batch_done = acc_valid & acc_last;

  ////////////////////////////////
  // output and staging
  ////////////////////////////////

  // output register empty or being taken this clock
  assign out_free = ~m_valid | m_ready;

  // staging always drains first to keep beats in order
  assign out_load  = out_free & (stg_valid | batch_done);
  assign stg_load  = batch_done & (~out_free | stg_valid);
  assign stg_clear = out_free & stg_valid & ~batch_done;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid   <= 1'b0;
      stg_valid <= 1'b0;
    end else begin
      if (out_load) begin
        m_valid <= 1'b1;
      end else if (out_free) begin
        m_valid <= 1'b0;
      end
      if (stg_load) begin
        stg_valid <= 1'b1;
      end else if (stg_clear) begin
        stg_valid <= 1'b0;
      end
    end
  end

  // data paths, held while m_valid waits on m_ready
  always_ff @(posedge clk) begin
    if (out_load) begin
      m_data <= stg_valid ? stg_data : asm_next;
    end
    if (stg_load) begin
      stg_data <= asm_next;
    end
  end

  ////////////////////////////////
  // flow control
  ////////////////////////////////

  // a batch in flight must still find a free slot when it completes
  assign room = ~stg_valid & ~(m_valid & assembling);

endmodule

`default_nettype wire

/* design/corr_top.sv */
`timescale 1ns/1ns
`default_nettype none

module corr_top (
  input  wire                                  clk,
  input  wire                                  rst_n,
  // input stream, one sample per lane
  input  wire                                  s_valid,
  output logic                                 s_ready,
  input  wire  [corr_pkg::s_data_width-1:0]    s_data,
  // output stream, one sum per lane
  output logic                                 m_valid,
  input  wire                                  m_ready,
  output logic [corr_pkg::m_data_width-1:0]    m_data
);

  // sequencer to engine
  logic              lane_valid;
  corr_pkg::lane_t   lane_idx;
  corr_pkg::sample_t lane_sample;
  logic              lane_last;

  // engine to collector
  logic              acc_valid;
  corr_pkg::lane_t   acc_lane;
  corr_pkg::acc_t    acc_value;
  logic              acc_last;

  // collector back to sequencer
  logic              room;

  lane_sequencer u_lane_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .room        (room),
    .s_ready     (s_ready),
    .lane_valid  (lane_valid),
    .lane_idx    (lane_idx),
    .lane_sample (lane_sample),
    .lane_last   (lane_last)
  );

  corr_engine u_corr_engine (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_valid  (lane_valid),
    .lane_idx    (lane_idx),
    .lane_sample (lane_sample),
    .lane_last   (lane_last),
    .acc_valid   (acc_valid),
    .acc_lane    (acc_lane),
    .acc_value   (acc_value),
    .acc_last    (acc_last)
  );

  result_collector u_result_collector (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_valid (acc_valid),
    .acc_lane  (acc_lane),
    .acc_value (acc_value),
    .acc_last  (acc_last),
    .m_ready   (m_ready),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .room      (room)
  );

endmodule

`default_nettype wire

/* testbench/corr_model.svh */
`ifndef CORR_MODEL_SVH
`define CORR_MODEL_SVH

// per-lane sample history, slot 0 holds the newest
corr_pkg::sample_t hist [corr_pkg::num_lanes][corr_pkg::corr_length];

// expected sums, num_lanes entries per beat with lane 0 first
corr_pkg::acc_t exp_q [$];

// empty history and no beats pending, as after a DUT reset
function automatic void model_clear();
  for (int l = 0; l < corr_pkg::num_lanes; l++) begin
    for (int j = 0; j < corr_pkg::corr_length; j++) begin
      hist[l][j] = '0;
    end
  end
  exp_q.delete();
endfunction

// correlation over one lane's history
function automatic corr_pkg::acc_t lane_sum(input int lane);
  corr_pkg::acc_t sum;
  corr_pkg::acc_t term;
  sum = '0;
  for (int j = 0; j < corr_pkg::corr_length; j++) begin
    term = corr_pkg::acc_t'(hist[lane][j]);
    // top code bit weighs the newest sample
    if (corr_pkg::corr_code[corr_pkg::corr_length-1-j]) begin
      sum = sum + term;
    end else begin
      sum = sum - term;
    end
  end
  return sum;
endfunction

// one accepted input beat, lane 0 in the low bits
function automatic void model_push(input logic [corr_pkg::s_data_width-1:0] data);
  for (int l = 0; l < corr_pkg::num_lanes; l++) begin
    for (int j = corr_pkg::corr_length - 1; j > 0; j--) begin
      hist[l][j] = hist[l][j-1];
    end
    hist[l][0] = corr_pkg::sample_t'(data[l*corr_pkg::sample_width +: corr_pkg::sample_width]);
    exp_q.push_back(lane_sum(l));
  end
endfunction

`endif

/* testbench/tb_corr_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_corr_top;

  localparam int wait_limit = 200;

  logic clk;
  logic rst_n;
  logic s_valid;
  logic s_ready;
  logic [corr_pkg::s_data_width-1:0] s_data;
  logic m_valid;
  logic m_ready;
  logic [corr_pkg::m_data_width-1:0] m_data;

  integer seed;
  int     err_cnt;
  int     timeout_cnt;
  int     beat_cnt;
  logic   bp_mode;
  // stalled output beat that must stay put
  logic   hold_pending;
  logic [corr_pkg::m_data_width-1:0] held_data;

  `include "corr_model.svh"

  corr_top u_corr_top (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_sum(input corr_pkg::acc_t got, input corr_pkg::acc_t exp, input int lane);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: beat %0d lane %0d sum %0d, expected %0d",
               $time, beat_cnt, lane, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // pop one expected beat and compare lane by lane
  task automatic take_beat();
    corr_pkg::acc_t got;
    if (exp_q.size() < corr_pkg::num_lanes) begin
      err_cnt++;
      $display("output beat at %0t ns has no input beat left to match it", $time);
    end else begin
      for (int l = 0; l < corr_pkg::num_lanes; l++) begin
        got = corr_pkg::acc_t'(m_data[l*corr_pkg::acc_width +: corr_pkg::acc_width]);
        check_sum(got, exp_q.pop_front(), l);
      end
      beat_cnt++;
    end
  endtask

  //////////////////////////////
  // monitor
  //////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      model_clear();
      hold_pending = 1'b0;
    end else begin
      if (hold_pending) begin
        if (!m_valid) begin
          err_cnt++;
          $display("m_valid dropped at %0t ns before its beat was taken", $time);
        end else if (m_data !== held_data) begin
          err_cnt++;
          $display("error at %0t ns: m_data changed while m_ready was low", $time);
        end
      end
      hold_pending = m_valid & ~m_ready;
      held_data    = m_data;
      if (m_valid && m_ready) begin
        take_beat();
      end
      if (s_valid && s_ready) begin
        model_push(s_data);
      end
    end
  end

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  // next falling edge, with fresh back-pressure
  task automatic step();
    @(negedge clk);
    if (bp_mode) begin
      m_ready = ($random(seed) & 3) != 0;
    end else begin
      m_ready = 1'b1;
    end
  endtask

  function automatic logic [corr_pkg::s_data_width-1:0] rand_beat(input logic extreme);
    logic [corr_pkg::s_data_width-1:0] data;
    for (int l = 0; l < corr_pkg::num_lanes; l++) begin
      if (extreme) begin
        data[l*corr_pkg::sample_width +: corr_pkg::sample_width] =
          (($random(seed) & 1) != 0) ? corr_pkg::sample_t'(31) : corr_pkg::sample_t'(-32);
      end else begin
        data[l*corr_pkg::sample_width +: corr_pkg::sample_width] =
          corr_pkg::sample_t'($random(seed));
      end
    end
    return data;
  endfunction

  function automatic logic [corr_pkg::s_data_width-1:0] fill_beat(input corr_pkg::sample_t v);
    return {corr_pkg::num_lanes{v}};
  endfunction

  // hold the beat until accepted, then a short random gap
  task automatic send_beat(input logic [corr_pkg::s_data_width-1:0] data);
    int   waited;
    int   gap;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    step();
    s_valid = 1'b1;
    s_data  = data;
    while (!taken && waited < wait_limit) begin
      @(posedge clk);
      taken = s_ready;
      step();
      waited++;
    end
    s_valid = 1'b0;
    if (!taken) begin
      timeout_cnt++;
      $display("timeout: input beat was never accepted");
    end
    gap = $random(seed) & 3;
    repeat (gap) step();
  endtask

  // wait until every expected beat came out
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < wait_limit) begin
      step();
      waited++;
    end
    if (exp_q.size() != 0) begin
      timeout_cnt++;
      $display("timeout: %0d expected sums never came out", exp_q.size());
    end
  endtask

  task automatic run_beats(input int n, input logic extreme);
    for (int i = 0; i < n && timeout_cnt == 0; i++) begin
      send_beat(rand_beat(extreme));
    end
  endtask

  // full-scale samples lined up with the code, largest possible sum
  task automatic run_code_match(input logic negate);
    logic plus;
    for (int i = 0; i < corr_pkg::corr_length && timeout_cnt == 0; i++) begin
      plus = corr_pkg::corr_code[i] ^ negate;
      send_beat(fill_beat(plus ? corr_pkg::sample_t'(31) : corr_pkg::sample_t'(-32)));
    end
  endtask

  task automatic reset_dut();
    step();
    s_valid = 1'b0;
    rst_n   = 1'b0;
    repeat (8) step();
    rst_n = 1'b1;
  endtask

  // idle window right after reset
  task automatic check_idle();
    repeat (4) begin
      step();
      check_level(s_ready, 1'b1, "s_ready");
      check_level(m_valid, 1'b0, "m_valid");
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    s_valid      = 1'b0;
    s_data       = '0;
    m_ready      = 1'b1;
    seed         = 32'hb231;
    err_cnt      = 0;
    timeout_cnt  = 0;
    beat_cnt     = 0;
    bp_mode      = 1'b0;
    hold_pending = 1'b0;
    held_data    = '0;

    reset_dut();
    check_idle();

    // zero history first, then a long free-flowing run
    run_beats(8, 1'b0);
    drain();
    run_beats(200, 1'b0);
    drain();

    // random back-pressure on the output
    bp_mode = 1'b1;
    run_beats(150, 1'b0);
    drain();

    // full-scale samples
    for (int i = 0; i < 10 && timeout_cnt == 0; i++) begin
      send_beat(fill_beat(corr_pkg::sample_t'(-32)));
    end
    for (int i = 0; i < 10 && timeout_cnt == 0; i++) begin
      send_beat(fill_beat(corr_pkg::sample_t'(31)));
    end
    run_code_match(1'b0);
    run_code_match(1'b1);
    run_beats(40, 1'b1);
    drain();

    // reset with beats still in flight
    run_beats(3, 1'b0);
    reset_dut();
    check_level(m_valid, 1'b0, "m_valid after reset");
    bp_mode = 1'b0;
    check_idle();
    run_beats(12, 1'b0);
    drain();

    $display("beats checked: %0d, errors: %0d, timeouts: %0d",
             beat_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && beat_cnt > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+testbench
common/corr_pkg.sv
corr_engine/tap_delay_ram.sv
corr_engine/corr_engine.sv
design/lane_sequencer.sv
design/result_collector.sv
design/corr_top.sv
testbench/tb_corr_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_corr_top
FILELIST  := tb.f
VFLAGS    := --binary --timing
OBJ_DIR   := obj_dir
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard testbench/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source, header or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$*

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	grep -qx 'all tests passed' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
